// ==== list.f ====
common/rv_pkg.sv
common/issue_if.sv
core/fetch_unit.sv
core/decoder.sv
core/regfile.sv
core/operand_forward.sv
core/alu_stage.sv
source/rv_core_top.sv
tb/tb_clkgen.sv
tb/rv_core_chk.sv
tb/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - common/rv_pkg.sv
  - common/issue_if.sv
  - core/fetch_unit.sv
  - core/decoder.sv
  - core/regfile.sv
  - core/operand_forward.sv
  - core/alu_stage.sv
  - source/rv_core_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/rv_core_chk.sv
      - tb/rv_core_tb.sv

// ==== tb/rv_core_tb.sv ====
// Testbench for the RV32I integer core with random programs and a reference model
`timescale 1ns/10ps

module rv_core_tb;
	import rv_pkg::*;

	logic                      clk;
	logic                      rst_n;
	logic                      run;
	logic                      imem_we;
	logic [IMEM_ADDR_BITS-1:0] imem_addr;
	word_t                     imem_wdata;
	reg_t                      xreg_addr;
	word_t                     xreg_data;
	logic                      retire_valid;
	reg_t                      retire_rd;
	word_t                     retire_data;

	word_t       prog [IMEM_DEPTH];   // Image for the next load
	bit          writes_word [IMEM_DEPTH];
	word_t       model [32];          // Architectural register model
	reg_t        exp_rd_q [$];        // Expected retirements, program order
	word_t       exp_val_q [$];
	int          checks = 0;
	int          errors = 0;
	int          retired = 0;
	int unsigned lcg_state;

	tb_clkgen u_clkgen (.clk, .rst_n);

	rv_core_top uut (
		.clk, .rst_n, .run, .imem_we, .imem_addr, .imem_wdata,
		.xreg_addr, .xreg_data, .retire_valid, .retire_rd, .retire_data
	);

	bind rv_core_top rv_core_chk u_chk (
		.clk(clk), .rst_n(rst_n), .run(run), .imem_we(imem_we),
		.retire_valid(retire_valid), .retire_rd(retire_rd),
		.xreg_addr(xreg_addr), .xreg_data(xreg_data)
	);

	//////////////////////////////
	// Random source and encoders
	//////////////////////////////
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int unsigned pick(input int unsigned n);
		int unsigned r;
		r = lcg_next();
		return (r >> 8) % n;  // Low bits of an LCG are weak
	endfunction

	function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic word_t i_type(input logic [2:0] f3, input int rd, input int rs1,
		input logic [11:0] imm);
		return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
	endfunction

	function automatic word_t u_type(input int rd, input logic [19:0] imm);
		return {imm, 5'(rd), 7'b0110111};
	endfunction

	// One random instruction, optionally from the non-writing kinds too
	function automatic word_t rand_instr(input bit with_bad);
		int unsigned kind;
		int          rd;
		int          rs1;
		int          rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		word_t       bits;
		kind = pick(with_bad ? 10 : 7);
		rd   = 1 + pick(15);
		rs1  = pick(16);
		rs2  = pick(16);
		f3   = 3'(pick(8));
		f7   = (pick(2) != 0) ? 7'h20 : 7'h00;
		bits = lcg_next();
		imm  = bits[19:8];
		case (kind)
			0, 1, 2: begin
				if (f3 != 3'd0 && f3 != 3'd5)
					f7 = 7'h00;                       // Only ADD/SUB and SRL/SRA have an alt
				return r_type(f7, f3, rd, rs1, rs2);
			end
			3, 4, 5: begin
				if (f3 == 3'd1)
					imm[11:5] = 7'h00;                // SLLI
				if (f3 == 3'd5)
					imm[11:5] = f7;                   // SRLI or SRAI
				return i_type(f3, rd, rs1, imm);
			end
			6: return u_type(rd, bits[27:8]);
			7: return r_type(7'h00, f3, 0, rs1, rs2);  // Legal but rd = x0
			8: return {bits[24:0], 7'b0000011};        // Load opcode, unsupported
			default: return r_type(7'h01, f3, rd, rs1, rs2);  // M extension, unsupported
		endcase
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////
	// RV32I semantics on the model array; returns 1 for a register write
	function automatic bit ref_exec(input word_t ins, output reg_t rd, output word_t val);
		word_t      a;
		word_t      b;
		word_t      imm_i;
		logic [2:0] f3;
		logic [6:0] f7;
		bit         ok;
		rd    = ins[11:7];
		f3    = ins[14:12];
		f7    = ins[31:25];
		a     = model[ins[19:15]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		b     = ins[5] ? model[ins[24:20]] : imm_i;  // Bit 5 splits OP from OP-IMM
		val   = '0;
		ok    = 1'b0;
		case (ins[6:0])
			7'b0110111: begin
				val = {ins[31:12], 12'b0};
				ok  = 1'b1;
			end
			7'b0110011, 7'b0010011: begin
				if (ins[5])
					ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				else if (f3 == 3'd1)
					ok = (f7 == 7'h00);
				else if (f3 == 3'd5)
					ok = (f7 == 7'h00 || f7 == 7'h20);
				else
					ok = 1'b1;
				case (f3)
					3'd0: val = (ins[5] && f7[5]) ? a - b : a + b;
					3'd1: val = a << b[4:0];
					3'd2: val = ($signed(a) < $signed(b));
					3'd3: val = (a < b);
					3'd4: val = a ^ b;
					3'd5: begin
						if (f7[5])
							val = $signed(a) >>> b[4:0];
						else
							val = a >> b[4:0];
					end
					3'd6: val = a | b;
					default: val = a & b;
				endcase
			end
			default: ok = 1'b0;
		endcase
		return ok && (rd != '0);
	endfunction

	//////////////////////////////
	// Tasks
	//////////////////////////////
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
		end
	endtask

	// Idle image, each word an ADDI x0,x0 with its own address
	task automatic fill_program();
		for (int a = 0; a < IMEM_DEPTH; a++)
			prog[a] = i_type(3'd0, 0, 0, 12'(a));
	endtask

	task automatic build_expected();
		reg_t  rd;
		word_t val;
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			writes_word[a] = ref_exec(prog[a], rd, val);
			if (writes_word[a]) begin
				model[rd] = val;
				exp_rd_q.push_back(rd);
				exp_val_q.push_back(val);
			end
		end
	endtask

	task automatic load_program();
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			@(posedge clk);
			imem_we    <= 1'b1;
			imem_addr  <= IMEM_ADDR_BITS'(a);
			imem_wdata <= prog[a];
		end
		@(posedge clk);
		imem_we <= 1'b0;
	endtask

	// Exactly n fetch edges see run high
	task automatic run_cycles(input int n);
		@(posedge clk);
		run <= 1'b1;
		repeat (n) @(posedge clk);
		run <= 1'b0;
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			errors++;
			$display("ERROR: reset was never released");
		end
	endtask

	task automatic wait_retired(input int target);
		int n;
		n = 0;
		while (retired < target && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (retired < target) begin
			errors++;
			$display("ERROR at %0t ns: only %0d of %0d retirements arrived", $time, retired, target);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_rd_q.size() != 0 && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (exp_rd_q.size() != 0) begin
			errors++;
			$display("ERROR at %0t ns: %0d expected retirements never came", $time,
				exp_rd_q.size());
		end
	endtask

	task automatic sweep_regs();
		for (int a = 0; a < 32; a++) begin
			@(posedge clk);
			xreg_addr <= reg_t'(a);
			@(negedge clk);
			check($sformatf("xreg_data[x%0d]", a), xreg_data, model[a]);
		end
	endtask

	//////////////////////////////
	// Retire monitor
	//////////////////////////////
	always @(negedge clk) begin
		if (rst_n && retire_valid) begin
			retired++;
			if (exp_rd_q.size() == 0) begin
				errors++;
				$display("ERROR at %0t ns: unexpected retirement to x%0d", $time, retire_rd);
			end else begin
				check("retire_rd", retire_rd, exp_rd_q.pop_front());
				check("retire_data", retire_data, exp_val_q.pop_front());
			end
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		int pos;
		int rd;
		int prev;
		int first;
		int held;
		run        = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		xreg_addr  = '0;
		lcg_state  = 32'd63993;
		for (int r = 0; r < 32; r++)
			model[r] = '0;
		wait_reset();

		// Idle after reset, nothing retires and all registers clear
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check("retire_valid", retire_valid, 1'b0);
		end
		sweep_regs();

		// Random mix, with fixed large shift amounts and negative immediates first
		fill_program();
		prog[0] = u_type(1, 20'h80000);
		prog[1] = i_type(3'd0, 2, 0, 12'hF25);
		prog[2] = i_type(3'd0, 3, 0, 12'd45);            // Shift amount 45 -> 13
		prog[3] = r_type(7'h20, 3'd5, 4, 1, 3);          // SRA
		prog[4] = r_type(7'h00, 3'd5, 5, 1, 3);          // SRL
		prog[5] = r_type(7'h00, 3'd1, 6, 2, 3);          // SLL
		for (int a = 6; a < 60; a++)
			prog[a] = rand_instr(1'b0);
		build_expected();
		load_program();
		run_cycles(IMEM_DEPTH);
		wait_drain();
		sweep_regs();

		// Dependency chains at distance 1, 2 and 3
		fill_program();
		pos = 0;
		for (int d = 1; d <= 3; d++) begin
			prev = 4 * d;
			for (int i = 0; i < 18; i++) begin
				rd = 4 * d + i % d;                      // Same register every d words
				case (i % 4)
					0: prog[pos] = i_type(3'd0, rd, rd, 12'(pick(4096)));
					1: prog[pos] = r_type(7'h00, 3'd0, rd, rd, prev);
					2: prog[pos] = r_type(7'h00, 3'd4, rd, prev, rd);
					default: prog[pos] = r_type(7'h20, 3'd0, rd, rd, prev);
				endcase
				prev = rd;
				pos++;
			end
		end
		build_expected();
		load_program();
		run_cycles(IMEM_DEPTH);
		wait_drain();
		sweep_regs();

		// x0 targets and undefined encodings
		fill_program();
		prog[0] = u_type(1, 20'hABCDE);
		prog[1] = i_type(3'd0, 0, 1, 12'hFFF);
		prog[2] = 32'hFFFF_FFFF;
		prog[3] = r_type(7'h00, 3'd0, 2, 0, 1);          // Reads x0 right after a write to it
		prog[4] = u_type(0, 20'h12345);
		prog[5] = r_type(7'h00, 3'd6, 3, 0, 0);
		prog[6] = i_type(3'd1, 4, 1, {7'h20, 5'd4});     // SLLI with bad funct7
		for (int a = 7; a < 56; a++)
			prog[a] = rand_instr(1'b1);
		build_expected();
		load_program();
		run_cycles(IMEM_DEPTH);
		wait_drain();
		sweep_regs();

		// Halt in the middle, drain, then resume at the next word
		fill_program();
		for (int a = 0; a < 48; a++)
			prog[a] = rand_instr(1'b0);
		build_expected();
		load_program();
		first = retired;
		for (int a = 0; a < 20; a++)
			first += writes_word[a];
		run_cycles(20);
		wait_retired(first);
		held = retired;
		repeat (8) @(negedge clk);
		check("retirements while halted", retired, held);
		run_cycles(IMEM_DEPTH - 20);
		wait_drain();
		sweep_regs();

		repeat (2) @(negedge clk);
		$display("Done: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, uut.u_chk.fails);
		if (errors == 0 && uut.u_chk.fails == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== tb/rv_core_chk.sv ====
// Concurrent protocol assertions bound onto the core top level
`timescale 1ns/10ps

module rv_core_chk (
	input logic          clk,
	input logic          rst_n,
	input logic          run,
	input logic          imem_we,
	input logic          retire_valid,
	input rv_pkg::reg_t  retire_rd,
	input rv_pkg::reg_t  xreg_addr,
	input rv_pkg::word_t xreg_data
);

	int fails = 0;  // Read by the testbench at the end

	//////////////////////////////
	// Top-level rules
	//////////////////////////////
	// Program loading only while halted
	a_load_halted: assert property (@(posedge clk) disable iff (!rst_n) run |-> !imem_we)
		else begin
			$error("imem_we strobed while run is high");
			fails++;
		end

	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !retire_valid)
		else begin
			$error("retire_valid high during reset");
			fails++;
		end

	// Writes to x0 never retire
	a_no_x0_retire: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> (retire_rd != '0))
		else begin
			$error("retire pulse with rd = x0");
			fails++;
		end

	a_x0_zero: assert property (@(posedge clk) (xreg_addr == '0) |-> (xreg_data == '0))
		else begin
			$error("x0 observed non-zero");
			fails++;
		end

endmodule

// ==== tb/tb_clkgen.sv ====
// Testbench clock and power-on reset source
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	// Reset held over the first 4 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== source/rv_core_top.sv ====
// Four-stage RV32I integer core top with retire and register observe ports
`timescale 1ns/10ps

module rv_core_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              run,           // Fetch enable
	input  logic                              imem_we,       // Program load strobe
	input  logic [rv_pkg::IMEM_ADDR_BITS-1:0] imem_addr,
	input  rv_pkg::word_t                     imem_wdata,
	input  rv_pkg::reg_t                      xreg_addr,     // Observe port
	output rv_pkg::word_t                     xreg_data,
	output logic                              retire_valid,  // Register write pulse
	output rv_pkg::reg_t                      retire_rd,
	output rv_pkg::word_t                     retire_data
);
	import rv_pkg::*;

	// IF/ID
	word_t   instr;
	logic    instr_valid;
	// Decode
	reg_t    rs1, rs2, rd;
	alu_op_e alu_op;
	logic    use_imm;
	word_t   imm;
	logic    wr_en;
	word_t   rs1_data, rs2_data;
	// Execute
	word_t   exe_result;

	issue_if iss ();

	fetch_unit u_fetch (
		.clk, .rst_n, .run, .imem_we, .imem_addr, .imem_wdata,
		.instr, .instr_valid
	);

	decoder u_dec (
		.instr, .instr_valid, .rs1, .rs2, .rd, .alu_op, .use_imm, .imm, .wr_en
	);

	// Written from the retire register
	regfile u_rf (
		.clk, .rst_n,
		.wr_en(retire_valid), .wr_addr(retire_rd), .wr_data(retire_data),
		.rs1, .rs2, .rs1_data, .rs2_data,
		.obs_addr(xreg_addr), .obs_data(xreg_data)
	);

	operand_forward u_fwd (
		.clk, .rst_n, .rs1, .rs2, .rd, .alu_op, .use_imm, .imm, .wr_en,
		.rs1_data, .rs2_data,
		.exe_valid(iss.valid), .exe_rd(iss.rd), .exe_result,
		.wb_valid(retire_valid), .wb_rd(retire_rd), .wb_data(retire_data),
		.issue(iss.producer)
	);

	alu_stage u_alu (
		.clk, .rst_n, .issue(iss.consumer), .exe_result,
		.retire_valid, .retire_rd, .retire_data
	);

endmodule

// ==== core/alu_stage.sv ====
// Execute stage ALU and the EXE/WB register that drives retirement
`timescale 1ns/10ps

module alu_stage (
	input  logic          clk,
	input  logic          rst_n,
	issue_if.consumer     issue,
	output rv_pkg::word_t exe_result,    // Forwarded back to decode
	output logic          retire_valid,
	output rv_pkg::reg_t  retire_rd,
	output rv_pkg::word_t retire_data
);
	import rv_pkg::*;

	logic [4:0] shamt;  // Low bits of op_b only

	assign shamt = issue.op_b[4:0];

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		case (issue.alu_op)
			ADD:    exe_result = issue.op_a + issue.op_b;
			SUB:    exe_result = issue.op_a - issue.op_b;
			AND:    exe_result = issue.op_a & issue.op_b;
			OR:     exe_result = issue.op_a | issue.op_b;
			XOR:    exe_result = issue.op_a ^ issue.op_b;
			SLT:    exe_result = word_t'($signed(issue.op_a) < $signed(issue.op_b));
			SLTU:   exe_result = word_t'(issue.op_a < issue.op_b);
			SLL:    exe_result = issue.op_a << shamt;
			SRL:    exe_result = issue.op_a >> shamt;
			SRA:    exe_result = word_t'($signed(issue.op_a) >>> shamt);  // Sign fill
			PASS_B: exe_result = issue.op_b;                              // LUI
			default: exe_result = '0;
		endcase
	end

	//////////////////////////////
	// EXE/WB register
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			retire_valid <= 1'b0;
		else
			retire_valid <= issue.valid;  // One pulse per writing instruction
	end

	// Payload follows the slot
	always_ff @(posedge clk) begin
		retire_rd   <= issue.rd;
		retire_data <= exe_result;
	end

endmodule

// ==== core/operand_forward.sv ====
// Operand forwarding into decode and the ID/EXE pipeline register
`timescale 1ns/10ps

module operand_forward (
	input  logic            clk,
	input  logic            rst_n,
	input  rv_pkg::reg_t    rs1,
	input  rv_pkg::reg_t    rs2,
	input  rv_pkg::reg_t    rd,
	input  rv_pkg::alu_op_e alu_op,
	input  logic            use_imm,
	input  rv_pkg::word_t   imm,
	input  logic            wr_en,
	input  rv_pkg::word_t   rs1_data,
	input  rv_pkg::word_t   rs2_data,
	input  logic            exe_valid,   // Execute slot
	input  rv_pkg::reg_t    exe_rd,
	input  rv_pkg::word_t   exe_result,
	input  logic            wb_valid,    // Write-back slot
	input  rv_pkg::reg_t    wb_rd,
	input  rv_pkg::word_t   wb_data,
	issue_if.producer       issue
);
	import rv_pkg::*;

	word_t fwd_a;
	word_t fwd_b;

	// Youngest producer wins; valid slots never carry x0
	function automatic word_t fwd_select(input reg_t rs, input word_t rf_data);
		if (exe_valid && exe_rd == rs)
			return exe_result;
		else if (wb_valid && wb_rd == rs)
			return wb_data;
		return rf_data;
	endfunction

	always_comb begin
		fwd_a = fwd_select(rs1, rs1_data);
		fwd_b = use_imm ? imm : fwd_select(rs2, rs2_data);  // Immediate overrides rs2
	end

	//////////////////////////////
	// ID/EXE register
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			issue.valid <= 1'b0;
		else
			issue.valid <= wr_en;
	end

	always_ff @(posedge clk) begin
		issue.rd     <= rd;
		issue.alu_op <= alu_op;
		issue.op_a   <= fwd_a;
		issue.op_b   <= fwd_b;
	end

endmodule

// ==== core/regfile.sv ====
// Integer register file, two decode read ports and one observe port
`timescale 1ns/10ps

module regfile (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          wr_en,     // From write-back
	input  rv_pkg::reg_t  wr_addr,
	input  rv_pkg::word_t wr_data,
	input  rv_pkg::reg_t  rs1,
	input  rv_pkg::reg_t  rs2,
	output rv_pkg::word_t rs1_data,
	output rv_pkg::word_t rs2_data,
	input  rv_pkg::reg_t  obs_addr,  // External observe
	output rv_pkg::word_t obs_data
);
	import rv_pkg::*;

	word_t regs [1:31];  // x1..x31, x0 is constant zero

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Combinational read with x0 tied low
	function automatic word_t read_reg(input reg_t addr);
		return (addr == '0) ? '0 : regs[addr];
	endfunction

	assign rs1_data = read_reg(rs1);
	assign rs2_data = read_reg(rs2);
	assign obs_data = read_reg(obs_addr);

endmodule

// ==== core/decoder.sv ====
// Decoder for RV32I OP, OP-IMM and LUI into ALU controls and immediate
`timescale 1ns/10ps

module decoder (
	input  rv_pkg::word_t   instr,
	input  logic            instr_valid,
	output rv_pkg::reg_t    rs1,
	output rv_pkg::reg_t    rs2,
	output rv_pkg::reg_t    rd,
	output rv_pkg::alu_op_e alu_op,
	output logic            use_imm,   // op_b from imm
	output rv_pkg::word_t   imm,
	output logic            wr_en      // Writing instruction
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_zero;   // funct7 = 0000000
	logic       f7_alt;    // funct7 = 0100000, SUB/SRA
	logic       is_reg;    // OP rather than OP_IMM
	logic       legal;     // Supported encoding
	word_t      i_imm;
	word_t      u_imm;
	word_t      sh_imm;

	// Instruction fields
	assign opcode  = instr[6:0];
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];
	assign rd      = instr[11:7];
	assign rs2     = instr[24:20];
	assign f7_zero = (funct7 == 7'b0000000);
	assign f7_alt  = (funct7 == 7'b0100000);
	assign is_reg  = (opcode == OP);

	// Immediates
	assign i_imm  = {{(XLEN-12){instr[31]}}, instr[31:20]};  // Sign extended
	assign u_imm  = {instr[31:12], 12'b0};
	assign sh_imm = {{(XLEN-REG_BITS){1'b0}}, instr[24:20]}; // shamt

	always_comb begin
		alu_op  = ADD;
		use_imm = 1'b0;
		imm     = i_imm;
		rs1     = instr[19:15];
		legal   = 1'b0;

		case (opcode)
			OP, OP_IMM: begin
				use_imm = !is_reg;
				legal   = 1'b1;
				// funct3 map shared by both forms
				case (funct3)
					3'b000: begin
						alu_op = (is_reg && f7_alt) ? SUB : ADD;
						legal  = !is_reg || f7_zero || f7_alt;  // ADDI ignores funct7
					end
					3'b001: begin
						alu_op = SLL;
						imm    = sh_imm;
						legal  = f7_zero;
					end
					3'b010: alu_op = SLT;
					3'b011: alu_op = SLTU;
					3'b100: alu_op = XOR;
					3'b101: begin
						alu_op = f7_alt ? SRA : SRL;
						imm    = sh_imm;
						legal  = f7_zero || f7_alt;
					end
					3'b110: alu_op = OR;
					default: alu_op = AND;
				endcase
				// Other OP funct7 values are undefined
				if (is_reg && funct3 != 3'b000 && funct3 != 3'b101)
					legal = f7_zero;
			end
			LUI: begin
				alu_op  = PASS_B;
				use_imm = 1'b1;
				imm     = u_imm;
				rs1     = '0;     // No source read
				legal   = 1'b1;
			end
			default: legal = 1'b0;  // Decodes as a bubble
		endcase
	end

	// x0 destination is a bubble too
	assign wr_en = instr_valid && legal && (rd != '0);

endmodule

// ==== core/fetch_unit.sv ====
// Fetch stage with PC, loadable instruction memory and the IF/ID register
`timescale 1ns/10ps

module fetch_unit (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              run,          // Fetch enable
	input  logic                              imem_we,      // Load strobe
	input  logic [rv_pkg::IMEM_ADDR_BITS-1:0] imem_addr,
	input  rv_pkg::word_t                     imem_wdata,
	output rv_pkg::word_t                     instr,        // To decode
	output logic                              instr_valid
);
	import rv_pkg::*;

	logic [IMEM_ADDR_BITS-1:0] pc;                 // Word address, wraps at IMEM_DEPTH
	word_t                     imem [IMEM_DEPTH];  // Program store
	word_t                     fetch_word;

	//////////////////////////////
	// Instruction memory
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;  // Loaded only while halted
	end

	assign fetch_word = imem[pc];  // Async read

	//////////////////////////////
	// PC
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (run)
			pc <= pc + 1'b1;  // Natural wrap
	end

	// IF/ID register
	// Bubbles while halted so nothing downstream writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr       <= NOP_INSTR;
			instr_valid <= 1'b0;
		end else if (run) begin
			instr       <= fetch_word;
			instr_valid <= 1'b1;
		end else begin
			instr       <= NOP_INSTR;
			instr_valid <= 1'b0;
		end
	end

endmodule

// ==== common/issue_if.sv ====
// Decoded and forwarded instruction slot from decode into execute
`timescale 1ns/10ps

interface issue_if;
	import rv_pkg::*;

	logic    valid;   // Slot writes a register
	reg_t    rd;      // Destination
	alu_op_e alu_op;  // Operation
	word_t   op_a;    // Forwarded source 1
	word_t   op_b;    // Forwarded source 2 or immediate

	// Decode side
	modport producer (
		output valid, rd, alu_op, op_a, op_b
	);

	// Execute side
	modport consumer (
		input valid, rd, alu_op, op_a, op_b
	);

endinterface

// ==== common/rv_pkg.sv ====
// Shared widths, encodings and types of the RV32I integer core
package rv_pkg;

	//////////////////////////////
	// Widths and sizes
	//////////////////////////////
	localparam int XLEN           = 32;                   // Data word width
	localparam int REG_BITS       = 5;                    // Register number width
	localparam int IMEM_ADDR_BITS = 6;                    // Word address into IMEM
	localparam int IMEM_DEPTH     = 1 << IMEM_ADDR_BITS;  // IMEM words

	typedef logic [XLEN-1:0]     word_t;
	typedef logic [REG_BITS-1:0] reg_t;

	// ADDI x0,x0,0
	localparam word_t NOP_INSTR = 32'h0000_0013;

	//////////////////////////////
	// Encodings
	//////////////////////////////
	// Major opcodes handled by the decoder
	typedef enum logic [6:0] {
		OP     = 7'b0110011,  // Register-register
		OP_IMM = 7'b0010011,  // Register-immediate
		LUI    = 7'b0110111   // Upper immediate
	} opcode_e;

	// ALU operations
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		AND    = 4'd2,
		OR     = 4'd3,
		XOR    = 4'd4,
		SLT    = 4'd5,   // Signed compare
		SLTU   = 4'd6,   // Unsigned compare
		SLL    = 4'd7,
		SRL    = 4'd8,
		SRA    = 4'd9,
		PASS_B = 4'd10   // Operand B straight through, for LUI
	} alu_op_e;

endpackage
